//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_minimum_trigger
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ** PASS **

SOURCES = $(shell cat $(FILELIST))
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_minimum_trigger.sv
`timescale 1ns/100ps

module tb_minimum_trigger;

    localparam int THRESHOLD     = 40;
    localparam int BASELINE_LOG2 = 4;
    localparam int POST_LEN      = 3;
    localparam int TIMER_DIV     = 5;
    localparam int FIFO_DEPTH    = 32;
    localparam int CLK_PERIOD    = 100;
    localparam int PKT_WORDS     = 1 + 2 * (POST_LEN + 1);
    localparam int AW            = trig_cfg_pkg::ADC_WIDTH;
    localparam int LW            = trig_cfg_pkg::LANE_WIDTH;
    localparam int SW            = trig_cfg_pkg::S_DATA_WIDTH;
    localparam int DRAIN_LIMIT   = 100;

    // Cycle budget of each test, the watchdog allows twice the sum
    localparam int RESET_CYCLES  = 8;
    localparam int CALIB_CYCLES  = 30;
    localparam int SINGLE_CYCLES = 60;
    localparam int WINDOW_CYCLES = 100;
    localparam int STALL_CYCLES  = 140;
    localparam int STAMP_CYCLES  = 180;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + CALIB_CYCLES + SINGLE_CYCLES
                                 + WINDOW_CYCLES + STALL_CYCLES + STAMP_CYCLES;

    logic AXIS_ACLK;
    logic AXIS_ARESETN;
    logic [SW-1:0] s_axis_tdata;
    logic s_axis_tvalid;
    logic s_axis_tready;
    logic [trig_pkt_pkg::M_DATA_WIDTH-1:0] m_axis_tdata;
    logic m_axis_tvalid;
    logic m_axis_tlast;
    logic m_axis_tuser;
    logic m_axis_tready;
    logic internal_fifo_full;

    logic [31:0] rng;
    int value_errors;
    int other_errors;
    int hdr_seen;
    logic beat_taken;

    // Reference model state
    logic [AW-1:0] exp_baseline;
    logic [15:0] model_evt;
    int cap_left;
    logic holdoff;
    logic keep_evt;
    logic [65:0] exp_q [$];
    logic [15:0] ts_seen [$];

    minimum_trigger #(
        .THRESHOLD     (THRESHOLD),
        .BASELINE_LOG2 (BASELINE_LOG2),
        .POST_LEN      (POST_LEN),
        .TIMER_DIV     (TIMER_DIV),
        .FIFO_DEPTH    (FIFO_DEPTH)
    ) u_dut (
        .AXIS_ACLK          (AXIS_ACLK),
        .AXIS_ARESETN       (AXIS_ARESETN),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tvalid      (s_axis_tvalid),
        .s_axis_tready      (s_axis_tready),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_tuser       (m_axis_tuser),
        .m_axis_tready      (m_axis_tready),
        .internal_fifo_full (internal_fifo_full)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) AXIS_ACLK = ~AXIS_ACLK;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // All lanes within center +-15
    function automatic logic [SW-1:0] noise_beat(input int center);
        logic [SW-1:0] d;
        d = '0;
        for (int i = 0; i < trig_cfg_pkg::LANES; i++)
        begin
            d[i*LW +: AW] = AW'(center - 15 + int'(next_rand() % 31));
        end
        return d;
    endfunction

    function automatic logic [SW-1:0] dip_beat(input int lane, input int value);
        logic [SW-1:0] d;
        d = noise_beat(int'(exp_baseline));
        d[lane*LW +: AW] = AW'(value);
        return d;
    endfunction

    task automatic check_hdr(input string name, input trig_pkt_pkg::hdr_word_t got,
                             input trig_pkt_pkg::hdr_word_t want);
        if (got !== want)
        begin
            $display("** Error: %s header got %h expected %h at %0t", name, got, want, $time);
            value_errors++;
        end
    endtask

    task automatic check_smp(input string name, input trig_pkt_pkg::smp_word_t got,
                             input trig_pkt_pkg::smp_word_t want);
        if (got !== want)
        begin
            $display("** Error: %s samples got %h expected %h at %0t", name, got, want, $time);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("** Error: %s got %h expected %h at %0t", name, got, want, $time);
            value_errors++;
        end
    endtask

    task automatic check_packets(input string name, input int first, input int want);
        if (hdr_seen - first != want)
        begin
            $display("%s: expected %0d packets but saw %0d", name, want, hdr_seen - first);
            other_errors++;
        end
    endtask

    // Predicts the output words of one accepted input beat
    task automatic model_beat(input logic [SW-1:0] d);
        logic [AW-1:0] mn;
        logic [2:0] ln;
        trig_pkt_pkg::out_word_u hw;
        mn = d[AW-1:0];
        ln = '0;
        for (int i = 1; i < trig_cfg_pkg::LANES; i++)
        begin
            if (d[i*LW +: AW] < mn)
            begin
                mn = d[i*LW +: AW];
                ln = 3'(i);
            end
        end
        if (holdoff)
        begin
            holdoff = 1'b0;
        end
        else
        begin
            if (cap_left == 0 && int'(mn) + THRESHOLD < int'(exp_baseline))
            begin
                keep_evt = (FIFO_DEPTH - exp_q.size()) >= PKT_WORDS;
                if (keep_evt)
                begin
                    hw.hdr.evt_num    = model_evt;
                    hw.hdr.time_stamp = '0;
                    hw.hdr.baseline   = exp_baseline;
                    hw.hdr.min_smp    = mn;
                    hw.hdr.min_lane   = ln;
                    hw.hdr.pad        = '0;
                    exp_q.push_back({1'b0, 1'b1, hw});
                    model_evt = model_evt + 16'd1;
                end
                cap_left = POST_LEN + 1;
            end
            if (cap_left > 0)
            begin
                if (keep_evt)
                begin
                    exp_q.push_back({1'b0, 1'b0, d[SW/2-1:0]});
                    exp_q.push_back({cap_left == 1, 1'b0, d[SW-1:SW/2]});
                end
                cap_left--;
                holdoff = cap_left == 0;
            end
        end
    endtask

    task automatic take_word();
        logic [65:0] e;
        trig_pkt_pkg::out_word_u got;
        trig_pkt_pkg::out_word_u want;
        trig_pkt_pkg::hdr_word_t want_hdr;
        got = m_axis_tdata;
        if (m_axis_tuser)
        begin
            hdr_seen++;
            ts_seen.push_back(got.hdr.time_stamp);
        end
        if (exp_q.size() == 0)
        begin
            $display("Output word %h arrived while no packet was expected", m_axis_tdata);
            other_errors++;
            return;
        end
        e = exp_q.pop_front();
        want = e[63:0];
        check_bit("m_axis_tuser", m_axis_tuser, e[64]);
        check_bit("m_axis_tlast", m_axis_tlast, e[65]);
        if (e[64])
        begin
            // Time stamp checked by spacing
            want_hdr = want.hdr;
            want_hdr.time_stamp = got.hdr.time_stamp;
            check_hdr("m_axis_tdata", got.hdr, want_hdr);
        end
        else
        begin
            check_smp("m_axis_tdata", got.smp, want.smp);
        end
    endtask

    always @(posedge AXIS_ACLK)
    begin
        if (AXIS_ARESETN && m_axis_tvalid && m_axis_tready)
        begin
            take_word();
        end
    end

    task automatic drive_beat(input logic [SW-1:0] d);
        @(negedge AXIS_ACLK);
        s_axis_tdata  = d;
        s_axis_tvalid = 1'b1;
        beat_taken    = s_axis_tready;
        if (beat_taken)
        begin
            model_beat(d);
        end
        @(posedge AXIS_ACLK);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge AXIS_ACLK);
            s_axis_tvalid = 1'b0;
        end
    endtask

    task automatic noise_beats(input int n);
        repeat (n) drive_beat(noise_beat(int'(exp_baseline)));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT)
        begin
            @(negedge AXIS_ACLK);
            n++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timed out waiting for %0d expected output words", exp_q.size());
            other_errors++;
            exp_q.delete();
        end
        // A few quiet cycles so stray words show up
        idle(4);
    endtask

    task automatic test_calibration();
        logic [SW-1:0] d;
        int sum;
        sum = 0;
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_bit("internal_fifo_full", internal_fifo_full, 1'b0);
        for (int b = 0; b < 2**BASELINE_LOG2; b++)
        begin
            d = noise_beat(2000);
            for (int i = 0; i < trig_cfg_pkg::LANES; i++)
            begin
                sum += int'(d[i*LW +: AW]);
            end
            drive_beat(d);
            check_bit("s_axis_tready", beat_taken, 1'b0);
        end
        exp_baseline = AW'(sum >> (BASELINE_LOG2 + 3));
        // calib_done, then ARMED, then tready
        idle(1);
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        idle(1);
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        idle(1);
        check_bit("s_axis_tready", s_axis_tready, 1'b1);
    endtask

    task automatic test_single_event();
        int first;
        first = hdr_seen;
        noise_beats(6);
        drive_beat(dip_beat(5, int'(exp_baseline) - THRESHOLD - 1));
        noise_beats(8);
        idle(1);
        wait_drain();
        check_packets("single event", first, 1);
    endtask

    task automatic test_window();
        int first;
        first = hdr_seen;
        noise_beats(4);
        // Exactly at the level, not below it
        drive_beat(dip_beat(2, int'(exp_baseline) - THRESHOLD));
        noise_beats(6);
        drive_beat(dip_beat(0, int'(exp_baseline) - 50));
        noise_beats(1);
        drive_beat(dip_beat(7, int'(exp_baseline) - 60));
        noise_beats(4);
        drive_beat(dip_beat(3, int'(exp_baseline) - 45));
        noise_beats(6);
        idle(1);
        wait_drain();
        check_packets("post window", first, 2);
    endtask

    task automatic test_stall();
        int first;
        first = hdr_seen;
        @(negedge AXIS_ACLK);
        m_axis_tready = 1'b0;
        repeat (5)
        begin
            drive_beat(dip_beat(1, int'(exp_baseline) - 70));
            noise_beats(7);
        end
        idle(3);
        check_bit("internal_fifo_full", internal_fifo_full, 1'b1);
        m_axis_tready = 1'b1;
        wait_drain();
        check_packets("output stall", first, 3);
        check_bit("internal_fifo_full", internal_fifo_full, 1'b0);
    endtask

    task automatic test_time_stamp(input int gap);
        logic [15:0] diff;
        int err;
        ts_seen.delete();
        drive_beat(dip_beat(4, int'(exp_baseline) - 50));
        noise_beats(gap - 1);
        drive_beat(dip_beat(6, int'(exp_baseline) - 50));
        noise_beats(6);
        idle(1);
        wait_drain();
        if (ts_seen.size() != 2)
        begin
            $display("Time stamp test expected 2 headers but saw %0d", ts_seen.size());
            other_errors++;
        end
        else
        begin
            diff = ts_seen[1] - ts_seen[0];
            err = int'(diff) * TIMER_DIV - gap;
            if (err >= TIMER_DIV || err <= -TIMER_DIV)
            begin
                $display("** Error: time_stamp delta got %h expected %h within one tick",
                         diff, 16'(gap / TIMER_DIV));
                value_errors++;
            end
        end
    endtask

    initial
    begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles before the tests finished",
                 2 * TOTAL_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        rng           = 32'h20e8538b;
        value_errors  = 0;
        other_errors  = 0;
        hdr_seen      = 0;
        beat_taken    = 1'b0;
        exp_baseline  = '0;
        model_evt     = '0;
        cap_left      = 0;
        holdoff       = 1'b0;
        keep_evt      = 1'b0;
        AXIS_ARESETN  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        repeat (RESET_CYCLES) @(posedge AXIS_ACLK);
        @(negedge AXIS_ACLK);
        AXIS_ARESETN  = 1'b1;
        m_axis_tready = 1'b1;

        test_calibration();
        test_single_event();
        test_window();
        test_stall();
        test_time_stamp(37);
        test_time_stamp(58);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- hdl/baseline_calc.sv
`timescale 1ns/100ps

module baseline_calc
#(
    parameter int BASELINE_LOG2 = 4
)
(
    input  logic                                    AXIS_ACLK,
    input  logic                                    AXIS_ARESETN,
    input  trig_cfg_pkg::exec_state_t               exec_state,
    input  logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]   s_axis_tdata,
    input  logic                                    s_axis_tvalid,
    output logic [trig_cfg_pkg::ADC_WIDTH-1:0]      baseline,
    output logic                                    calib_done
);

    localparam int AW = trig_cfg_pkg::ADC_WIDTH;
    localparam int SUM_W = AW + 3;
    localparam int ACC_W = SUM_W + BASELINE_LOG2;

    logic [SUM_W-1:0] beat_sum;
    logic [ACC_W-1:0] acc;
    logic [ACC_W-1:0] acc_next;
    logic [BASELINE_LOG2:0] beat_cnt;
    logic calibrating;
    logic last_beat;

    // Sum of all lanes in one beat
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < trig_cfg_pkg::LANES; i++)
        begin
            beat_sum = beat_sum + SUM_W'(s_axis_tdata[i*trig_cfg_pkg::LANE_WIDTH +: AW]);
        end
    end

    assign calibrating = (exec_state == trig_cfg_pkg::CALIB) && !calib_done && s_axis_tvalid;
    assign last_beat = beat_cnt == (BASELINE_LOG2+1)'(2**BASELINE_LOG2 - 1);
    assign acc_next = acc + ACC_W'(beat_sum);

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            acc        <= '0;
            beat_cnt   <= '0;
            calib_done <= 1'b0;
        end
        else if (calibrating)
        begin
            acc      <= acc_next;
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat)
            begin
                calib_done <= 1'b1;
            end
        end
    end

    // Average over all samples, truncated
    always_ff @(posedge AXIS_ACLK)
    begin
        if (calibrating && last_beat)
        begin
            baseline <= AW'(acc_next >> (BASELINE_LOG2 + 3));
        end
    end

endmodule

//--- hdl/event_packetizer.sv
`timescale 1ns/100ps

module event_packetizer
#(
    parameter int POST_LEN   = 3,
    parameter int FIFO_DEPTH = 32
)
(
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  logic [trig_cfg_pkg::ADC_WIDTH-1:0]        baseline,
    input  logic                                      trig,
    input  logic [trig_cfg_pkg::TIME_WIDTH-1:0]       time_stamp,
    input  logic [trig_cfg_pkg::ADC_WIDTH-1:0]        trig_min,
    input  logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0]   trig_lane,
    input  logic                                      cap_valid,
    input  logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]     cap_data,
    input  logic                                      cap_last,
    output logic [trig_pkt_pkg::M_DATA_WIDTH-1:0]     m_axis_tdata,
    output logic                                      m_axis_tvalid,
    output logic                                      m_axis_tlast,
    output logic                                      m_axis_tuser,
    input  logic                                      m_axis_tready,
    output logic                                      internal_fifo_full
);

    localparam int FW = trig_pkt_pkg::M_DATA_WIDTH + 2;
    localparam int PKT_WORDS = 1 + 2 * (POST_LEN + 1);
    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int SPW = trig_pkt_pkg::SMP_PER_WORD;
    localparam int LW = trig_cfg_pkg::LANE_WIDTH;

    // Word layout is {tlast, tuser, data}
    logic [FW-1:0] mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic [1:0] wr_n;
    logic [FW-1:0] w0;
    logic [FW-1:0] w1;
    logic rd;
    logic room;
    logic keep;
    logic flush;
    logic [15:0] evt_num;
    trig_pkt_pkg::out_word_u hdr_w;
    trig_pkt_pkg::out_word_u lo_w;
    trig_pkt_pkg::out_word_u hi_w;
    trig_pkt_pkg::smp_word_t skid;

    assign m_axis_tvalid = count != '0;
    assign {m_axis_tlast, m_axis_tuser, m_axis_tdata} = mem[rd_ptr];
    assign rd = m_axis_tvalid && m_axis_tready;
    assign room = (CW'(FIFO_DEPTH) - count) >= CW'(PKT_WORDS);
    assign count_next = count + CW'(wr_n) - CW'(rd);

    always_comb
    begin
        hdr_w.hdr.evt_num    = evt_num;
        hdr_w.hdr.time_stamp = time_stamp;
        hdr_w.hdr.baseline   = baseline;
        hdr_w.hdr.min_smp    = trig_min;
        hdr_w.hdr.min_lane   = trig_lane;
        hdr_w.hdr.pad        = '0;
        for (int i = 0; i < SPW; i++)
        begin
            lo_w.smp.lane[i] = cap_data[i*LW +: LW];
            hi_w.smp.lane[i] = cap_data[(i+SPW)*LW +: LW];
        end
    end

    // Up to two words per cycle; high half waits in the skid register
    always_comb
    begin
        wr_n = 2'd0;
        w0   = '0;
        w1   = '0;
        if (trig && room)
        begin
            wr_n = 2'd2;
            w0   = {2'b01, hdr_w};
            w1   = {2'b00, lo_w};
        end
        else if (cap_valid && keep && !trig)
        begin
            wr_n = 2'd2;
            w0   = {2'b00, skid};
            w1   = {2'b00, lo_w};
        end
        else if (flush)
        begin
            wr_n = 2'd1;
            w0   = {2'b10, skid};
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (wr_n != 2'd0)
        begin
            mem[wr_ptr] <= w0;
        end
        if (wr_n == 2'd2)
        begin
            mem[wr_ptr + 1'b1] <= w1;
        end
        if (cap_valid)
        begin
            skid <= hi_w.smp;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            wr_ptr             <= '0;
            rd_ptr             <= '0;
            count              <= '0;
            keep               <= 1'b0;
            flush              <= 1'b0;
            evt_num            <= '0;
            internal_fifo_full <= 1'b0;
        end
        else
        begin
            wr_ptr             <= wr_ptr + PW'(wr_n);
            rd_ptr             <= rd_ptr + PW'(rd);
            count              <= count_next;
            internal_fifo_full <= (CW'(FIFO_DEPTH) - count_next) < CW'(PKT_WORDS);
            flush              <= cap_valid && cap_last && (trig ? room : keep);
            if (trig)
            begin
                // Drop the whole event when short of room
                keep <= room;
                if (room)
                begin
                    evt_num <= evt_num + 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/min_trigger.sv
`timescale 1ns/100ps

module min_trigger
#(
    parameter int THRESHOLD = 40,
    parameter int POST_LEN  = 3,
    parameter int TIMER_DIV = 5
)
(
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  trig_cfg_pkg::exec_state_t                 exec_state,
    input  logic [trig_cfg_pkg::ADC_WIDTH-1:0]        baseline,
    input  logic                                      beat_valid,
    input  logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]     beat,
    input  logic [trig_cfg_pkg::ADC_WIDTH-1:0]        beat_min,
    input  logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0]   min_lane,
    output logic                                      trig,
    output logic [trig_cfg_pkg::TIME_WIDTH-1:0]       time_stamp,
    output logic [trig_cfg_pkg::ADC_WIDTH-1:0]        trig_min,
    output logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0]   trig_lane,
    output logic                                      cap_valid,
    output logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]     cap_data,
    output logic                                      cap_last
);

    localparam int AW = trig_cfg_pkg::ADC_WIDTH;
    localparam int CNT_W = $clog2(POST_LEN + 1) + 1;
    localparam int DIV_W = $clog2(TIMER_DIV + 1);

    logic [AW-1:0] level;
    logic level_ok;
    logic armed;
    logic hit;
    logic capturing;
    logic [CNT_W-1:0] post_cnt;
    logic [DIV_W-1:0] div_cnt;
    logic [trig_cfg_pkg::TIME_WIDTH-1:0] ts_cnt;

    assign armed = exec_state == trig_cfg_pkg::ARMED;
    assign hit = armed && beat_valid && !capturing && level_ok && (beat_min < level);

    // Tracks the baseline until it is frozen at the move to ARMED
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!armed)
        begin
            level    <= baseline - AW'(THRESHOLD);
            level_ok <= baseline >= AW'(THRESHOLD);
        end
    end

    // Time stamp prescaler
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            div_cnt <= '0;
            ts_cnt  <= '0;
        end
        else if (armed)
        begin
            if (div_cnt == DIV_W'(TIMER_DIV - 1))
            begin
                div_cnt <= '0;
                ts_cnt  <= ts_cnt + 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            capturing <= 1'b0;
            post_cnt  <= '0;
            trig      <= 1'b0;
            cap_valid <= 1'b0;
            cap_last  <= 1'b0;
        end
        else
        begin
            trig      <= hit;
            cap_valid <= 1'b0;
            cap_last  <= 1'b0;
            if (hit)
            begin
                capturing <= 1'b1;
                post_cnt  <= CNT_W'(POST_LEN);
                cap_valid <= 1'b1;
                cap_last  <= POST_LEN == 0;
            end
            else if (capturing && beat_valid)
            begin
                if (post_cnt == '0)
                begin
                    // Hold-off beat, rearm without compare
                    capturing <= 1'b0;
                end
                else
                begin
                    cap_valid <= 1'b1;
                    cap_last  <= post_cnt == CNT_W'(1);
                    post_cnt  <= post_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (hit)
        begin
            time_stamp <= ts_cnt;
            trig_min   <= beat_min;
            trig_lane  <= min_lane;
        end
        if (beat_valid)
        begin
            cap_data <= beat;
        end
    end

endmodule

//--- hdl/minimum_trigger.sv
`timescale 1ns/100ps

module minimum_trigger
#(
    parameter int THRESHOLD     = 40,
    parameter int BASELINE_LOG2 = 4,
    parameter int POST_LEN      = 3,
    parameter int TIMER_DIV     = 5,
    parameter int FIFO_DEPTH    = 32
)
(
    input  logic                                    AXIS_ACLK,
    input  logic                                    AXIS_ARESETN,
    input  logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]   s_axis_tdata,
    input  logic                                    s_axis_tvalid,
    output logic                                    s_axis_tready,
    output logic [trig_pkt_pkg::M_DATA_WIDTH-1:0]   m_axis_tdata,
    output logic                                    m_axis_tvalid,
    output logic                                    m_axis_tlast,
    output logic                                    m_axis_tuser,
    input  logic                                    m_axis_tready,
    output logic                                    internal_fifo_full
);

    trig_cfg_pkg::exec_state_t exec_state;
    logic [trig_cfg_pkg::ADC_WIDTH-1:0] baseline;
    logic calib_done;
    logic accept;
    logic beat_valid;
    logic [trig_cfg_pkg::S_DATA_WIDTH-1:0] beat;
    logic [trig_cfg_pkg::ADC_WIDTH-1:0] beat_min;
    logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0] min_lane;
    logic trig;
    logic [trig_cfg_pkg::TIME_WIDTH-1:0] time_stamp;
    logic [trig_cfg_pkg::ADC_WIDTH-1:0] trig_min;
    logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0] trig_lane;
    logic cap_valid;
    logic [trig_cfg_pkg::S_DATA_WIDTH-1:0] cap_data;
    logic cap_last;

    assign accept = s_axis_tvalid && s_axis_tready;

    // Calibrate once, then stay armed; tready follows a cycle later
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            exec_state    <= trig_cfg_pkg::CALIB;
            s_axis_tready <= 1'b0;
        end
        else
        begin
            if (calib_done)
            begin
                exec_state <= trig_cfg_pkg::ARMED;
            end
            s_axis_tready <= exec_state == trig_cfg_pkg::ARMED;
        end
    end

    baseline_calc #(
        .BASELINE_LOG2 (BASELINE_LOG2)
    ) u_baseline (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .exec_state    (exec_state),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .baseline      (baseline),
        .calib_done    (calib_done)
    );

    sample_unpack u_unpack (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .s_axis_tdata (s_axis_tdata),
        .accept       (accept),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .beat_min     (beat_min),
        .min_lane     (min_lane)
    );

    min_trigger #(
        .THRESHOLD (THRESHOLD),
        .POST_LEN  (POST_LEN),
        .TIMER_DIV (TIMER_DIV)
    ) u_trigger (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .exec_state   (exec_state),
        .baseline     (baseline),
        .beat_valid   (beat_valid),
        .beat         (beat),
        .beat_min     (beat_min),
        .min_lane     (min_lane),
        .trig         (trig),
        .time_stamp   (time_stamp),
        .trig_min     (trig_min),
        .trig_lane    (trig_lane),
        .cap_valid    (cap_valid),
        .cap_data     (cap_data),
        .cap_last     (cap_last)
    );

    event_packetizer #(
        .POST_LEN   (POST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_packetizer (
        .AXIS_ACLK          (AXIS_ACLK),
        .AXIS_ARESETN       (AXIS_ARESETN),
        .baseline           (baseline),
        .trig               (trig),
        .time_stamp         (time_stamp),
        .trig_min           (trig_min),
        .trig_lane          (trig_lane),
        .cap_valid          (cap_valid),
        .cap_data           (cap_data),
        .cap_last           (cap_last),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_tuser       (m_axis_tuser),
        .m_axis_tready      (m_axis_tready),
        .internal_fifo_full (internal_fifo_full)
    );

endmodule

//--- hdl/sample_unpack.sv
`timescale 1ns/100ps

module sample_unpack
(
    input  logic                                      AXIS_ACLK,
    input  logic                                      AXIS_ARESETN,
    input  logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]     s_axis_tdata,
    input  logic                                      accept,
    output logic                                      beat_valid,
    output logic [trig_cfg_pkg::S_DATA_WIDTH-1:0]     beat,
    output logic [trig_cfg_pkg::ADC_WIDTH-1:0]        beat_min,
    output logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0]   min_lane
);

    localparam int AW = trig_cfg_pkg::ADC_WIDTH;
    localparam int LW = trig_cfg_pkg::LANE_WIDTH;
    localparam int IW = trig_cfg_pkg::LANE_IDX_WIDTH;

    logic [AW-1:0] v0 [trig_cfg_pkg::LANES];
    logic [AW-1:0] v1 [4];
    logic [IW-1:0] i1 [4];
    logic [AW-1:0] v2 [2];
    logic [IW-1:0] i2 [2];
    logic [AW-1:0] v3;
    logic [IW-1:0] i3;

    // Three-level compare tree, lower lane kept on a tie
    always_comb
    begin
        for (int i = 0; i < trig_cfg_pkg::LANES; i++)
        begin
            v0[i] = s_axis_tdata[i*LW +: AW];
        end
        for (int i = 0; i < 4; i++)
        begin
            v1[i] = (v0[2*i+1] < v0[2*i]) ? v0[2*i+1] : v0[2*i];
            i1[i] = (v0[2*i+1] < v0[2*i]) ? IW'(2*i+1) : IW'(2*i);
        end
        for (int i = 0; i < 2; i++)
        begin
            v2[i] = (v1[2*i+1] < v1[2*i]) ? v1[2*i+1] : v1[2*i];
            i2[i] = (v1[2*i+1] < v1[2*i]) ? i1[2*i+1] : i1[2*i];
        end
        v3 = (v2[1] < v2[0]) ? v2[1] : v2[0];
        i3 = (v2[1] < v2[0]) ? i2[1] : i2[0];
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            beat_valid <= 1'b0;
        end
        else
        begin
            beat_valid <= accept;
        end
    end

    always_ff @(posedge AXIS_ACLK)
    begin
        if (accept)
        begin
            beat     <= s_axis_tdata;
            beat_min <= v3;
            min_lane <= i3;
        end
    end

endmodule

//--- hdl/trig_cfg_pkg.sv
package trig_cfg_pkg;

    // ADC sample format on the input stream
    localparam int ADC_WIDTH = 12;
    localparam int LANE_WIDTH = 16;
    localparam int LANES = 8;

    // One input beat carries all lanes
    localparam int S_DATA_WIDTH = LANES * LANE_WIDTH;
    localparam int LANE_IDX_WIDTH = 3;

    // Event time stamp, wraps freely
    localparam int TIME_WIDTH = 16;

    // Execution state, driven by the top to all blocks
    typedef enum logic
    {
        CALIB = 1'b0,
        ARMED = 1'b1
    } exec_state_t;

endpackage

//--- hdl/trig_pkt_pkg.sv
package trig_pkt_pkg;

    localparam int M_DATA_WIDTH = 64;

    // Samples per output word
    localparam int SMP_PER_WORD = M_DATA_WIDTH / trig_cfg_pkg::LANE_WIDTH;

    // First word of an event, flagged by tuser
    typedef struct packed
    {
        logic [15:0]                               evt_num;
        logic [trig_cfg_pkg::TIME_WIDTH-1:0]       time_stamp;
        logic [trig_cfg_pkg::ADC_WIDTH-1:0]        baseline;
        logic [trig_cfg_pkg::ADC_WIDTH-1:0]        min_smp;
        logic [trig_cfg_pkg::LANE_IDX_WIDTH-1:0]   min_lane;
        logic [4:0]                                pad;
    } hdr_word_t;

    // Half of an input beat, lane 0 in the low bits
    typedef struct packed
    {
        logic [SMP_PER_WORD-1:0][trig_cfg_pkg::LANE_WIDTH-1:0] lane;
    } smp_word_t;

    // tuser selects which view applies
    typedef union packed
    {
        hdr_word_t hdr;
        smp_word_t smp;
    } out_word_u;

endpackage

//--- project.f
hdl/trig_cfg_pkg.sv
hdl/trig_pkt_pkg.sv
hdl/sample_unpack.sv
hdl/baseline_calc.sv
hdl/min_trigger.sv
hdl/event_packetizer.sv
hdl/minimum_trigger.sv
bench/tb_minimum_trigger.sv
